// ==== src/residuPkg.sv ====
`default_nettype none

package residuPkg;

	////////////////////////////////////////
	// Widths and sizes

	localparam int addrWidth = 12;
	localparam int wordWidth = 32;
	localparam int sampleWidth = 16;
	localparam int memDepth = 1024;
	localparam int memIndexWidth = $clog2(memDepth);
	localparam int lgWidth = 6;

	// Filter order M, coefficients a[0..M]
	localparam int filterOrder = 10;
	// Wide enough to hold M+1 at loop exit
	localparam int orderWidth = $clog2(filterOrder + 2);

	localparam int shiftAmount = 3;
	localparam int shiftCountWidth = $clog2(shiftAmount + 1);

	localparam logic [31:0] roundConst = 32'h0000_8000;

	// Saturation limits of a long word
	localparam logic [31:0] longMax = 32'h7FFF_FFFF;
	localparam logic [31:0] longMin = 32'h8000_0000;

	////////////////////////////////////////
	// Enumerations

	typedef enum logic [3:0]
	{
		idle,
		outerLoop,
		fetchFirst,
		firstMult,
		innerLoop,
		fetchPair,
		accumulate,
		shift,
		roundStore,
		nextSample,
		finish
	} ctrlState;

	typedef enum logic [1:0]
	{
		opNone,
		opLMult,
		opLMac,
		opLAdd
	} opCode;

	////////////////////////////////////////
	// Request bundles

	typedef struct packed
	{
		opCode opcode;
		logic [sampleWidth-1:0] a;
		logic [sampleWidth-1:0] b;
		logic [31:0] c;
	} opRequest;

	typedef struct packed
	{
		logic [addrWidth-1:0] addrA;
		logic [addrWidth-1:0] addrX;
	} memReadReq;

	typedef struct packed
	{
		logic en;
		logic [addrWidth-1:0] addr;
		logic [wordWidth-1:0] data;
	} memWriteReq;

endpackage

`default_nettype wire

// ==== src/basicOpUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module basicOpUnit
(
	input wire residuPkg::opRequest opReq,
	output logic [31:0] opResult
);

	////////////////////////////////////////
	// Fixed-point primitives

	// Doubled product, -1 * -1 clips to max
	function automatic logic [31:0] lMult
	(
		input logic [residuPkg::sampleWidth-1:0] x,
		input logic [residuPkg::sampleWidth-1:0] y
	);
		logic signed [31:0] product;
		product = $signed(x) * $signed(y);
		if (product == 32'sh4000_0000)
			lMult = residuPkg::longMax;
		else
			lMult = {product[30:0], 1'b0};
	endfunction

	// Add with clipping on overflow
	function automatic logic [31:0] lAdd
	(
		input logic [31:0] x,
		input logic [31:0] y
	);
		logic [31:0] sum;
		sum = x + y;
		if ((x[31] == y[31]) && (sum[31] != x[31]))
		begin
			if (x[31])
				lAdd = residuPkg::longMin;
			else
				lAdd = residuPkg::longMax;
		end
		else
			lAdd = sum;
	endfunction

	////////////////////////////////////////
	// Operation select

	logic [31:0] product;
	logic [31:0] longOperand;

	assign product = lMult(opReq.a, opReq.b);

	// Second long operand travels split across a and b
	assign longOperand = {opReq.a, opReq.b};

	always_comb
	begin
		case (opReq.opcode)
			residuPkg::opLMult:
				opResult = product;
			residuPkg::opLMac:
				opResult = lAdd(opReq.c, product);
			residuPkg::opLAdd:
				opResult = lAdd(opReq.c, longOperand);
			default:
				opResult = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/shiftUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module shiftUnit
(
	input wire clk,
	input wire reset,
	input wire shlReady,
	input wire [31:0] shlValue,
	output logic shlDone,
	output logic [31:0] shlResult
);

	typedef enum logic {shlIdle, shlShifting} shlState;

	shlState state;
	logic [residuPkg::shiftCountWidth-1:0] stepCount;
	logic [31:0] held;

	// One bit left with clipping once the sign would flip
	function automatic logic [31:0] satDouble(input logic [31:0] value);
		if (value[31] != value[30])
			satDouble = value[31] ? residuPkg::longMin : residuPkg::longMax;
		else
			satDouble = {value[30:0], 1'b0};
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= shlIdle;
			stepCount <= '0;
			shlDone <= 1'b0;
		end
		else
		begin
			shlDone <= 1'b0;
			case (state)
				shlIdle:
					if (shlReady)
					begin
						stepCount <= {{(residuPkg::shiftCountWidth - 1){1'b0}}, 1'b1};
						state <= shlShifting;
					end
				shlShifting:
				begin
					stepCount <= stepCount + 1'b1;
					if (int'(stepCount) == residuPkg::shiftAmount - 1)
					begin
						shlDone <= 1'b1;
						state <= shlIdle;
					end
				end
				default:
					state <= shlIdle;
			endcase
		end
	end

	// First step taken on capture
	always_ff @(posedge clk)
	begin
		if ((state == shlIdle) && shlReady)
			held <= satDouble(shlValue);
		else if (state == shlShifting)
			held <= satDouble(held);
	end

	assign shlResult = held;

	// Request dropped in the done cycle so no second capture follows
	readyDroppedOnDone: assert property (@(posedge clk) disable iff (reset)
		shlDone |-> !shlReady);

endmodule

`default_nettype wire

// ==== src/residuMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module residuMemory
(
	input wire clk,
	input wire residuPkg::memReadReq readReq,
	input wire residuPkg::memWriteReq writeReq,
	input wire hostWriteEn,
	input wire [residuPkg::addrWidth-1:0] hostAddr,
	input wire [residuPkg::wordWidth-1:0] hostWriteData,
	output logic [residuPkg::wordWidth-1:0] readDataA,
	output logic [residuPkg::wordWidth-1:0] readDataX,
	output logic [residuPkg::wordWidth-1:0] hostReadData
);

	logic [residuPkg::wordWidth-1:0] mem [residuPkg::memDepth];

	////////////////////////////////////////
	// Write side

	// Filter and host writes share the array
	always_ff @(posedge clk)
	begin
		if (writeReq.en)
			mem[writeReq.addr[residuPkg::memIndexWidth-1:0]] <= writeReq.data;
		else if (hostWriteEn)
			mem[hostAddr[residuPkg::memIndexWidth-1:0]] <= hostWriteData;
	end

	////////////////////////////////////////
	// Read side

	// Coefficient and signal ports
	always_ff @(posedge clk)
	begin
		readDataA <= mem[readReq.addrA[residuPkg::memIndexWidth-1:0]];
		readDataX <= mem[readReq.addrX[residuPkg::memIndexWidth-1:0]];
	end

	// Host readback
	always_ff @(posedge clk)
	begin
		hostReadData <= mem[hostAddr[residuPkg::memIndexWidth-1:0]];
	end

	// Host may only write while the filter is idle
	noWriteCollision: assert property (@(posedge clk)
		!(writeReq.en && hostWriteEn));

endmodule

`default_nettype wire

// ==== src/residuController.sv ====
`timescale 1ns/1ps
`default_nettype none

module residuController
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire [residuPkg::addrWidth-1:0] aBase,
	input wire [residuPkg::addrWidth-1:0] xBase,
	input wire [residuPkg::addrWidth-1:0] yBase,
	input wire [residuPkg::lgWidth-1:0] lg,
	input wire [residuPkg::wordWidth-1:0] readDataA,
	input wire [residuPkg::wordWidth-1:0] readDataX,
	input wire [31:0] opResult,
	input wire shlDone,
	input wire [31:0] shlResult,
	output logic done,
	output residuPkg::memReadReq readReq,
	output residuPkg::memWriteReq writeReq,
	output residuPkg::opRequest opReq,
	output logic shlReady,
	output logic [31:0] shlValue
);

	residuPkg::ctrlState state;
	residuPkg::ctrlState nextState;

	// Loop counters
	logic [residuPkg::lgWidth-1:0] i;
	logic [residuPkg::orderWidth-1:0] j;

	// Operands and run parameters
	logic [residuPkg::sampleWidth-1:0] operand;
	logic [31:0] s;
	logic [residuPkg::addrWidth-1:0] aReg;
	logic [residuPkg::addrWidth-1:0] xReg;
	logic [residuPkg::addrWidth-1:0] yReg;
	logic [residuPkg::lgWidth-1:0] lgReg;

	// Counters widened for address math
	logic [residuPkg::addrWidth-1:0] iAddr;
	logic [residuPkg::addrWidth-1:0] jAddr;

	assign iAddr = {{(residuPkg::addrWidth - residuPkg::lgWidth){1'b0}}, i};
	assign jAddr = {{(residuPkg::addrWidth - residuPkg::orderWidth){1'b0}}, j};

	////////////////////////////////////////
	// State and loop counters

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= residuPkg::idle;
			i <= '0;
			j <= {{(residuPkg::orderWidth - 1){1'b0}}, 1'b1};
		end
		else
		begin
			state <= nextState;
			case (state)
				residuPkg::idle:
					if (start)
						i <= '0;
				residuPkg::firstMult:
					j <= {{(residuPkg::orderWidth - 1){1'b0}}, 1'b1};
				residuPkg::accumulate:
					j <= j + 1'b1;
				residuPkg::nextSample:
					i <= i + 1'b1;
				default:
					;
			endcase
		end
	end

	// Operand, accumulator and latched run parameters
	always_ff @(posedge clk)
	begin
		case (state)
			residuPkg::idle:
				if (start)
				begin
					aReg <= aBase;
					xReg <= xBase;
					yReg <= yBase;
					lgReg <= lg;
				end
			residuPkg::fetchFirst:
				operand <= readDataX[residuPkg::sampleWidth-1:0];
			residuPkg::firstMult:
				s <= opResult;
			residuPkg::fetchPair:
				operand <= readDataA[residuPkg::sampleWidth-1:0];
			residuPkg::accumulate:
				s <= opResult;
			residuPkg::shift:
				if (shlDone)
					s <= shlResult;
			default:
				;
		endcase
	end

	////////////////////////////////////////
	// Next state and requests

	always_comb
	begin
		nextState = state;
		readReq = '0;
		writeReq = '0;
		opReq = '0;
		shlReady = 1'b0;
		shlValue = s;
		done = 1'b0;
		case (state)
			residuPkg::idle:
				if (start)
					nextState = residuPkg::outerLoop;
			residuPkg::outerLoop:
				if (i < lgReg)
				begin
					readReq.addrX = xReg + iAddr;
					nextState = residuPkg::fetchFirst;
				end
				else
					nextState = residuPkg::finish;
			residuPkg::fetchFirst:
			begin
				readReq.addrA = aReg;
				nextState = residuPkg::firstMult;
			end
			residuPkg::firstMult:
			begin
				opReq.opcode = residuPkg::opLMult;
				opReq.a = operand;
				opReq.b = readDataA[residuPkg::sampleWidth-1:0];
				nextState = residuPkg::innerLoop;
			end
			residuPkg::innerLoop:
				if (int'(j) <= residuPkg::filterOrder)
				begin
					readReq.addrA = aReg + jAddr;
					nextState = residuPkg::fetchPair;
				end
				else
					nextState = residuPkg::shift;
			residuPkg::fetchPair:
			begin
				// May reach the history below xBase
				readReq.addrX = xReg + iAddr - jAddr;
				nextState = residuPkg::accumulate;
			end
			residuPkg::accumulate:
			begin
				opReq.opcode = residuPkg::opLMac;
				opReq.a = operand;
				opReq.b = readDataX[residuPkg::sampleWidth-1:0];
				opReq.c = s;
				nextState = residuPkg::innerLoop;
			end
			residuPkg::shift:
			begin
				shlReady = !shlDone;
				if (shlDone)
					nextState = residuPkg::roundStore;
			end
			residuPkg::roundStore:
			begin
				opReq.opcode = residuPkg::opLAdd;
				opReq.a = residuPkg::roundConst[31:16];
				opReq.b = residuPkg::roundConst[15:0];
				opReq.c = s;
				writeReq.en = 1'b1;
				writeReq.addr = yReg + iAddr;
				writeReq.data = {{(residuPkg::wordWidth - 16){opResult[31]}}, opResult[31:16]};
				nextState = residuPkg::nextSample;
			end
			residuPkg::nextSample:
				nextState = residuPkg::outerLoop;
			residuPkg::finish:
			begin
				done = 1'b1;
				nextState = residuPkg::idle;
			end
			default:
				nextState = residuPkg::idle;
		endcase
	end

	// Shift unit answers only while the controller waits on it
	shlDoneInShift: assert property (@(posedge clk) disable iff (reset)
		shlDone |-> state == residuPkg::shift);

	// Stores stay inside the y range of the run
	writeInRange: assert property (@(posedge clk) disable iff (reset)
		writeReq.en |-> i < lgReg);

endmodule

`default_nettype wire

// ==== src/residuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module residuTop
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire [residuPkg::addrWidth-1:0] aBase,
	input wire [residuPkg::addrWidth-1:0] xBase,
	input wire [residuPkg::addrWidth-1:0] yBase,
	input wire [residuPkg::lgWidth-1:0] lg,
	output logic done,
	input wire hostWriteEn,
	input wire [residuPkg::addrWidth-1:0] hostAddr,
	input wire [residuPkg::wordWidth-1:0] hostWriteData,
	output logic [residuPkg::wordWidth-1:0] hostReadData
);

	residuPkg::memReadReq readReq;
	residuPkg::memWriteReq writeReq;
	residuPkg::opRequest opReq;
	logic [residuPkg::wordWidth-1:0] readDataA;
	logic [residuPkg::wordWidth-1:0] readDataX;
	logic [31:0] opResult;
	logic shlReady;
	logic shlDone;
	logic [31:0] shlValue;
	logic [31:0] shlResult;

	// Decode
	residuController residuController_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.aBase(aBase),
		.xBase(xBase),
		.yBase(yBase),
		.lg(lg),
		.readDataA(readDataA),
		.readDataX(readDataX),
		.opResult(opResult),
		.shlDone(shlDone),
		.shlResult(shlResult),
		.done(done),
		.readReq(readReq),
		.writeReq(writeReq),
		.opReq(opReq),
		.shlReady(shlReady),
		.shlValue(shlValue)
	);

	// Execute
	basicOpUnit basicOpUnit_i
	(
		.opReq(opReq),
		.opResult(opResult)
	);

	shiftUnit shiftUnit_i
	(
		.clk(clk),
		.reset(reset),
		.shlReady(shlReady),
		.shlValue(shlValue),
		.shlDone(shlDone),
		.shlResult(shlResult)
	);

	// Result
	residuMemory residuMemory_i
	(
		.clk(clk),
		.readReq(readReq),
		.writeReq(writeReq),
		.hostWriteEn(hostWriteEn),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.readDataA(readDataA),
		.readDataX(readDataX),
		.hostReadData(hostReadData)
	);

endmodule

`default_nettype wire

// ==== tb/residuTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module residuTopTb;

	logic clk;
	logic reset;
	logic start;
	logic [residuPkg::addrWidth-1:0] aBase;
	logic [residuPkg::addrWidth-1:0] xBase;
	logic [residuPkg::addrWidth-1:0] yBase;
	logic [residuPkg::lgWidth-1:0] lg;
	logic done;
	logic hostWriteEn;
	logic [residuPkg::addrWidth-1:0] hostAddr;
	logic [residuPkg::wordWidth-1:0] hostWriteData;
	logic [residuPkg::wordWidth-1:0] hostReadData;

	logic [31:0] stim [0:511];
	int valueErrors;
	int controlErrors;
	int cycleCount;
	int cycleLimit;
	bit runActive;
	bit donePrev;

	residuTop residuTop_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.aBase(aBase),
		.xBase(xBase),
		.yBase(yBase),
		.lg(lg),
		.done(done),
		.hostWriteEn(hostWriteEn),
		.hostAddr(hostAddr),
		.hostWriteData(hostWriteData),
		.hostReadData(hostReadData)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	////////////////////////////////////////
	// Watchdog and done monitor

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("timeout: no finish after %0d cycles", cycleCount);
			$display("** FAIL **");
			$finish;
		end
	end

	// Sampled mid-cycle, away from the driving edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			assert (!done || runActive)
			else
			begin
				controlErrors++;
				$display("done pulsed at %0t while no run was active", $time);
			end
			assert (!(done && donePrev))
			else
			begin
				controlErrors++;
				$display("done stayed high for more than one cycle at %0t", $time);
			end
		end
		donePrev = done;
	end

	////////////////////////////////////////
	// Host port helpers

	function automatic logic [31:0] fillWord(input logic [residuPkg::addrWidth-1:0] addr);
		fillWord = {addr, 4'hA, ~addr, 4'h5};
	endfunction

	task automatic writeWord(input logic [residuPkg::addrWidth-1:0] addr, input logic [31:0] data);
		@(posedge clk);
		hostWriteEn <= 1'b1;
		hostAddr <= addr;
		hostWriteData <= data;
		@(posedge clk);
		hostWriteEn <= 1'b0;
	endtask

	task automatic readWord(input logic [residuPkg::addrWidth-1:0] addr, output logic [31:0] data);
		@(posedge clk);
		hostWriteEn <= 1'b0;
		hostAddr <= addr;
		@(posedge clk);
		@(negedge clk);
		data = hostReadData;
	endtask

	task automatic checkWord(input logic [residuPkg::addrWidth-1:0] addr, input logic [31:0] expected);
		logic [31:0] got;
		readWord(addr, got);
		assert (got === expected)
		else
		begin
			valueErrors++;
			$display("error at %0t: hostReadData[%h] expected %h, got %h",
				$time, addr, expected, got);
		end
	endtask

	// Start one run and wait for done, with an optional stray start mid-run
	task automatic runFilter(input logic [residuPkg::addrWidth-1:0] a,
		input logic [residuPkg::addrWidth-1:0] x,
		input logic [residuPkg::addrWidth-1:0] y,
		input logic [residuPkg::lgWidth-1:0] n,
		input bit strayStart);
		bit seen;
		seen = 0;
		@(posedge clk);
		start <= 1'b1;
		aBase <= a;
		xBase <= x;
		yBase <= y;
		lg <= n;
		runActive = 1;
		@(posedge clk);
		start <= 1'b0;
		if (strayStart)
		begin
			repeat (5)
				@(posedge clk);
			start <= 1'b1;
			aBase <= 12'h300;
			xBase <= 12'h320;
			yBase <= 12'h340;
			lg <= 6'd5;
			@(posedge clk);
			start <= 1'b0;
		end
		while (!seen)
		begin
			@(negedge clk);
			seen = done;
		end
		@(negedge clk);
		runActive = 0;
	endtask

	////////////////////////////////////////
	// Main sequence

	initial
	begin
		int nCases;
		int ptr;
		int totalLg;
		int n;
		logic [residuPkg::addrWidth-1:0] a;
		logic [residuPkg::addrWidth-1:0] x;
		logic [residuPkg::addrWidth-1:0] y;

		reset = 1'b1;
		start = 1'b0;
		aBase = '0;
		xBase = '0;
		yBase = '0;
		lg = '0;
		hostWriteEn = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		valueErrors = 0;
		controlErrors = 0;
		cycleCount = 0;
		cycleLimit = 0;
		runActive = 0;
		donePrev = 0;

		$readmemh("tb/residuInput.txt", stim);
		nCases = stim[0];

		// Limit scales with the total sample count
		ptr = 1;
		totalLg = 0;
		for (int c = 0; c < nCases; c++)
		begin
			n = stim[ptr + 3];
			totalLg += n;
			ptr += 4 + 11 + n + 10 + n;
		end
		cycleLimit = 200 * totalLg + 2000;

		repeat (8)
			@(posedge clk);
		reset <= 1'b0;

		ptr = 1;
		for (int c = 0; c < nCases; c++)
		begin
			a = stim[ptr];
			x = stim[ptr + 1];
			y = stim[ptr + 2];
			n = stim[ptr + 3];
			ptr += 4;
			for (int k = 0; k <= residuPkg::filterOrder; k++)
				writeWord(a + k, stim[ptr + k]);
			ptr += 11;
			// History sits below xBase
			for (int k = 0; k < n + 10; k++)
				writeWord(x - 10 + k, stim[ptr + k]);
			ptr += n + 10;
			for (int k = -1; k <= n; k++)
				writeWord(y + k, fillWord(y + k));

			runFilter(a, x, y, n, c == 0);

			for (int k = 0; k < n; k++)
				checkWord(y + k, stim[ptr + k]);
			ptr += n;
			// Guard words either side of y
			checkWord(y - 1, fillWord(y - 1));
			checkWord(y + n, fillWord(y + n));
		end

		repeat (4)
			@(posedge clk);
		$display("value errors: %0d, control errors: %0d", valueErrors, controlErrors);
		if (valueErrors == 0 && controlErrors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== residuTop.f ====
src/residuPkg.sv
src/basicOpUnit.sv
src/shiftUnit.sv
src/residuMemory.sv
src/residuController.sv
src/residuTop.sv
tb/residuTopTb.sv

// ==== tb/residuInput.txt ====
// Case count, then per case: aBase xBase yBase lg / a[0..10] / x[-10..lg-1] then lg expected y words
// All values hex, signal words sign-extended to 32 bits
4
10 40 80 4
1000 800 0 0 0 0 0 0 0 0 0
1234 FFFFABCD 77 0 5A5A 9 FFFFFFF0 300 42 3 64 FFFFFFCE 7 200 66 0 FFFFFFEE 204
100 120 140 2
8000 7FFF 0 0 0 0 0 0 0 0 0
11 22 33 44 55 66 77 88 99 7FFF FFFF8000 7FFF 7FFF FFFF8000
10 40 180 0
0 0 0 0 0 0 0 0 0 0 0
1 2 3 4 5 6 7 8 9 A
200 220 260 3
4000 0 0 0 0 0 0 0 0 0 2000
5 FFFFFFFD 1 11 22 33 44 55 66 77 A FFFFFFEC 100 32 FFFFFFAA 402
